// ==== include/peripheral_defines.svh ====
// Peripheral glue constants
// Port addresses, EMS map sizing and bus idle value

`ifndef PERIPHERAL_DEFINES_SVH
`define PERIPHERAL_DEFINES_SVH

// EMS map registers, 260h..263h
`define PORT_EMS_BASE 16'h0260

// Printer data latch
`define PORT_LPT 16'h0378

// Tandy video page register, write only
`define PORT_TANDY_PAGE 16'h03DF

// Tandy NMI mask, A0h..A7h
`define PORT_NMI_MASK_BASE 16'h00A0

// Map entries in the page frame
`define EMS_PAGES 4

// EMS write codes
`define EMS_DISABLE_CODE 8'hFF
`define EMS_MAP_LIMIT 8'h80

// Data bus value when no chipset port answers
`define IDLE_READ_DATA 8'h00

`endif

// ==== design/peripheral_pkg.sv ====
// Peripheral glue types
// CPU-side bus, port selects, EMS map entries and enums

package peripheral_pkg;

    // ISA-style CPU bus, strobes active low
    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  write_data;
        logic        io_read_n;
        logic        io_write_n;
        logic        memory_read_n;
        logic        address_enable_n;
    } io_bus_t;

    // One bit per decoded port group
    typedef struct packed {
        logic ems;
        logic lpt;
        logic tandy_page;
        logic nmi_mask;
    } io_select_t;

    // One EMS map slot
    typedef struct packed {
        logic [6:0] page;
        logic       enable;
    } ems_entry_t;

    // Page frame base segment
    typedef enum logic [1:0] {
        FRAME_A000,
        FRAME_C000,
        FRAME_D000
    } ems_frame_e;

    // Read-back source picked by the mux
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_EMS,
        SRC_LPT,
        SRC_NMI_MASK
    } read_source_e;

endpackage

// ==== design/io_port_decoder.sv ====
// I/O port decoder
// Turns the CPU bus into a one-hot select for the glue ports

`timescale 1ns/1ps
`include "peripheral_defines.svh"

module io_port_decoder (
    input  peripheral_pkg::io_bus_t    bus_i,
    input  logic                       ems_enabled_i,
    input  logic                       tandy_video_i,
    output peripheral_pkg::io_select_t select_o
);

    logic io_request;
    logic port_access;
    logic ems_match;
    logic lpt_match;
    logic tandy_page_match;
    logic nmi_mask_match;

    assign io_request  = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign port_access = io_request & ~bus_i.address_enable_n;

    // Four-port block
    assign ems_match = ({bus_i.address[15:2], 2'b00} == `PORT_EMS_BASE);

    // Single ports
    assign lpt_match        = (bus_i.address[15:0] == `PORT_LPT);
    assign tandy_page_match = (bus_i.address[15:0] == `PORT_TANDY_PAGE);

    // Eight-port block
    assign nmi_mask_match = ({bus_i.address[15:3], 3'b000} == `PORT_NMI_MASK_BASE);

    always_comb begin
        select_o = '0;
        if (port_access) begin
            select_o.ems        = ems_match & ems_enabled_i;
            select_o.lpt        = lpt_match;
            select_o.tandy_page = tandy_page_match;
            // Only present on Tandy machines
            select_o.nmi_mask   = nmi_mask_match & tandy_video_i;
        end

        // Port windows never overlap
        a_select_onehot: assert ($onehot0(select_o))
            else $error("io_port_decoder: overlapping selects %b", select_o);
    end

endmodule

// ==== design/ems_mapper.sv ====
// EMS page mapper
// Four map registers written through ports 260h..263h, with
// bank hits for the page frame and read-back of the addressed entry

`timescale 1ns/1ps
`include "peripheral_defines.svh"

module ems_mapper (
    input  logic                       clock,
    input  logic                       reset,
    input  peripheral_pkg::io_bus_t    bus_i,
    input  peripheral_pkg::io_select_t select_i,
    input  peripheral_pkg::ems_frame_e ems_frame_i,
    output logic [`EMS_PAGES-1:0]      bank_hit_o,
    output logic [7:0]                 read_data_o
);
    import peripheral_pkg::*;

    ems_entry_t ems_map [`EMS_PAGES];
    ems_entry_t read_entry;
    ems_entry_t next_entry;
    ems_entry_t write_entry;
    logic [1:0] write_index;
    logic       write_enable;
    logic       io_request;
    logic [3:0] frame_nibble;

    assign io_request = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign read_entry = ems_map[bus_i.address[1:0]];

    // FFh disables, below 80h maps, anything else keeps the entry
    always_comb begin
        next_entry = read_entry;
        if (bus_i.write_data == `EMS_DISABLE_CODE) begin
            next_entry.enable = 1'b0;
        end else if (bus_i.write_data < `EMS_MAP_LIMIT) begin
            next_entry.page   = bus_i.write_data[6:0];
            next_entry.enable = 1'b1;
        end
    end

    // Write stage
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_enable <= 1'b0;
        end else begin
            write_enable <= select_i.ems & ~bus_i.io_write_n;
        end
    end

    always_ff @(posedge clock) begin
        write_index <= bus_i.address[1:0];
        write_entry <= next_entry;
    end

    // Map registers, updated one edge after the write sample
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `EMS_PAGES; i++) begin
                ems_map[i] <= '0;
            end
        end else if (write_enable) begin
            ems_map[write_index] <= write_entry;
        end
    end

    assign read_data_o = read_entry.enable ? {1'b0, read_entry.page} : `EMS_DISABLE_CODE;

    // Frame segment high nibble
    always_comb begin
        case (ems_frame_i)
            FRAME_A000: frame_nibble = 4'hA;
            FRAME_C000: frame_nibble = 4'hC;
            FRAME_D000: frame_nibble = 4'hD;
            default:    frame_nibble = 4'hA;
        endcase
    end

    // Each entry owns one 16K window of the 64K frame
    always_comb begin
        for (int n = 0; n < `EMS_PAGES; n++) begin
            bank_hit_o[n] = ~io_request & ems_map[n].enable
                            & (bus_i.address[19:14] == {frame_nibble, 2'(n)});
        end
    end

    a_single_bank_hit: assert property (
        @(posedge clock) disable iff (reset) $onehot0(bank_hit_o)
    ) else $error("ems_mapper: several bank hits %b", bank_hit_o);

endmodule

// ==== design/io_latch_bank.sv ====
// Port latches
// Printer data, Tandy NMI mask and Tandy video page registers

`timescale 1ns/1ps

module io_latch_bank (
    input  logic                       clock,
    input  logic                       reset,
    input  peripheral_pkg::io_bus_t    bus_i,
    input  peripheral_pkg::io_select_t select_i,
    output logic [7:0]                 lpt_data_o,
    output logic [7:0]                 nmi_mask_o,
    output logic [7:0]                 tandy_page_o
);

    logic write_strobe;

    assign write_strobe = ~bus_i.io_write_n;

    // Printer port idles high
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o <= 8'hFF;
        end else if (select_i.lpt && write_strobe) begin
            lpt_data_o <= bus_i.write_data;
        end
    end

    // NMI masked at power up
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_o <= 8'hFF;
        end else if (select_i.nmi_mask && write_strobe) begin
            nmi_mask_o <= bus_i.write_data;
        end
    end

    // Page register for the external video block
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            tandy_page_o <= 8'h00;
        end else if (select_i.tandy_page && write_strobe) begin
            tandy_page_o <= bus_i.write_data;
        end
    end

endmodule

// ==== design/readback_mux.sv ====
// Chipset read-back
// Picks the answering port on an I/O read and registers the data bus

`timescale 1ns/1ps
`include "peripheral_defines.svh"

module readback_mux (
    input  logic                       clock,
    input  logic                       reset,
    input  peripheral_pkg::io_bus_t    bus_i,
    input  peripheral_pkg::io_select_t select_i,
    input  logic [7:0]                 ems_data_i,
    input  logic [7:0]                 lpt_data_i,
    input  logic [7:0]                 nmi_mask_i,
    output logic [7:0]                 data_bus_o,
    output logic                       from_chipset_o
);
    import peripheral_pkg::*;

    read_source_e read_source;
    logic [7:0]   read_data;

    // Priority EMS, printer, NMI mask
    always_comb begin
        read_source = SRC_NONE;
        if (~bus_i.io_read_n) begin
            if (select_i.ems) begin
                read_source = SRC_EMS;
            end else if (select_i.lpt) begin
                read_source = SRC_LPT;
            end else if (select_i.nmi_mask) begin
                read_source = SRC_NMI_MASK;
            end
        end
    end

    always_comb begin
        case (read_source)
            SRC_EMS:      read_data = ems_data_i;
            SRC_LPT:      read_data = lpt_data_i;
            SRC_NMI_MASK: read_data = nmi_mask_i;
            default:      read_data = `IDLE_READ_DATA;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_o     <= `IDLE_READ_DATA;
            from_chipset_o <= 1'b0;
        end else begin
            data_bus_o     <= read_data;
            from_chipset_o <= (read_source != SRC_NONE);
        end
    end

    // Bus released after any sample nobody claims
    a_idle_release: assert property (
        @(posedge clock) disable iff (reset)
        (read_source == SRC_NONE) |=> (!from_chipset_o && data_bus_o == `IDLE_READ_DATA)
    ) else $error("readback_mux: chipset drove the bus after an idle sample");

endmodule

// ==== design/peripheral_glue_top.sv ====
// Peripheral glue top
// Port decode, EMS mapper, port latches and the chipset read-back bus

`timescale 1ns/1ps
`include "peripheral_defines.svh"

module peripheral_glue_top (
    input  logic                       clock,
    input  logic                       reset,
    input  peripheral_pkg::io_bus_t    bus_i,
    input  logic                       ems_enabled_i,
    input  logic                       tandy_video_i,
    input  peripheral_pkg::ems_frame_e ems_frame_i,
    output logic [`EMS_PAGES-1:0]      ems_bank_hit_o,
    output logic [7:0]                 tandy_page_o,
    output logic [7:0]                 data_bus_o,
    output logic                       from_chipset_o
);
    import peripheral_pkg::*;

    io_select_t port_select;
    logic [7:0] ems_read_data;
    logic [7:0] lpt_data;
    logic [7:0] nmi_mask;

    io_port_decoder u_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .tandy_video_i (tandy_video_i),
        .select_o      (port_select)
    );

    ems_mapper u_ems_mapper (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (bus_i),
        .select_i    (port_select),
        .ems_frame_i (ems_frame_i),
        .bank_hit_o  (ems_bank_hit_o),
        .read_data_o (ems_read_data)
    );

    io_latch_bank u_latch_bank (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .select_i     (port_select),
        .lpt_data_o   (lpt_data),
        .nmi_mask_o   (nmi_mask),
        .tandy_page_o (tandy_page_o)
    );

    readback_mux u_readback (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus_i),
        .select_i       (port_select),
        .ems_data_i     (ems_read_data),
        .lpt_data_i     (lpt_data),
        .nmi_mask_i     (nmi_mask),
        .data_bus_o     (data_bus_o),
        .from_chipset_o (from_chipset_o)
    );

endmodule

// ==== test/tb_peripheral_glue.sv ====
// Peripheral glue testbench
// Table of bus operations applied to the top level, with
// read-back, Tandy page and bank hit checks

`timescale 1ns/1ps
`include "peripheral_defines.svh"

module tb_peripheral_glue;
    import peripheral_pkg::*;

    typedef enum logic [1:0] {
        OP_IO_WRITE,
        OP_IO_READ,
        OP_MEM_PROBE,
        OP_PAGE_CHECK
    } step_op_e;

    typedef struct packed {
        step_op_e    op;
        logic [19:0] address;
        logic [7:0]  data;
        ems_frame_e  frame;
        logic        tandy_video;
        logic        ems_enabled;
        logic [15:0] expected;
    } step_t;

    logic                  clock;
    logic                  reset;
    io_bus_t               bus;
    logic                  ems_enabled;
    logic                  tandy_video;
    ems_frame_e            ems_frame;
    logic [`EMS_PAGES-1:0] ems_bank_hit;
    logic [7:0]            tandy_page;
    logic [7:0]            data_bus;
    logic                  from_chipset;

    step_t steps[$];
    string step_names[$];
    int    errors;
    int    cycle_count;
    int    cycle_limit;

    peripheral_glue_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus),
        .ems_enabled_i  (ems_enabled),
        .tandy_video_i  (tandy_video),
        .ems_frame_i    (ems_frame),
        .ems_bank_hit_o (ems_bank_hit),
        .tandy_page_o   (tandy_page),
        .data_bus_o     (data_bus),
        .from_chipset_o (from_chipset)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic io_bus_t idle_bus();
        io_bus_t idle;
        idle.address          = '0;
        idle.write_data       = '0;
        idle.io_read_n        = 1'b1;
        idle.io_write_n       = 1'b1;
        idle.memory_read_n    = 1'b1;
        idle.address_enable_n = 1'b0;
        return idle;
    endfunction

    function automatic logic [19:0] io_address(input logic [15:0] port);
        return {4'h0, port};
    endfunction

    // Upper byte holds from_chipset, lower byte the data bus
    function automatic logic [15:0] bus_result(input logic driven, input logic [7:0] data);
        return {7'b0000000, driven, data};
    endfunction

    function automatic logic [15:0] hit_result(input logic [`EMS_PAGES-1:0] hits);
        return {12'h000, hits};
    endfunction

    function automatic logic [15:0] page_result(input logic [7:0] page);
        return {8'h00, page};
    endfunction

    task automatic check_value(
        input string       name,
        input logic [15:0] expected,
        input logic [15:0] actual
    );
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_step(
        input string       name,
        input step_op_e    op,
        input logic [19:0] address,
        input logic [7:0]  data,
        input ems_frame_e  frame,
        input logic        tandy,
        input logic        ems_on,
        input logic [15:0] expected
    );
        step_t step;
        step.op          = op;
        step.address     = address;
        step.data        = data;
        step.frame       = frame;
        step.tandy_video = tandy;
        step.ems_enabled = ems_on;
        step.expected    = expected;
        steps.push_back(step);
        step_names.push_back(name);
    endtask

    // Each row gives name, operation, address, data, frame, tandy video, EMS on and expected
    task automatic build_table();
        add_step("lpt_reset", OP_IO_READ, io_address(`PORT_LPT),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b1, 8'hFF));
        add_step("nmi_reset", OP_IO_READ, io_address(`PORT_NMI_MASK_BASE),
                 8'h00, FRAME_A000, 1'b1, 1'b1, bus_result(1'b1, 8'hFF));
        add_step("ems_reset", OP_IO_READ, io_address(`PORT_EMS_BASE),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b1, 8'hFF));
        add_step("page_reset", OP_PAGE_CHECK, io_address(16'h0000),
                 8'h00, FRAME_A000, 1'b0, 1'b1, page_result(8'h00));
        // Latches
        add_step("lpt_write", OP_IO_WRITE, io_address(`PORT_LPT),
                 8'h5A, FRAME_A000, 1'b0, 1'b1, 16'h0000);
        add_step("lpt_read", OP_IO_READ, io_address(`PORT_LPT),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b1, 8'h5A));
        add_step("page_write", OP_IO_WRITE, io_address(`PORT_TANDY_PAGE),
                 8'h3C, FRAME_A000, 1'b0, 1'b1, 16'h0000);
        add_step("page_value", OP_PAGE_CHECK, io_address(16'h0000),
                 8'h00, FRAME_A000, 1'b0, 1'b1, page_result(8'h3C));
        add_step("page_not_readable", OP_IO_READ, io_address(`PORT_TANDY_PAGE),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b0, 8'h00));
        add_step("nmi_write", OP_IO_WRITE, io_address(`PORT_NMI_MASK_BASE + 16'h0003),
                 8'h80, FRAME_A000, 1'b1, 1'b1, 16'h0000);
        add_step("nmi_read", OP_IO_READ, io_address(`PORT_NMI_MASK_BASE),
                 8'h00, FRAME_A000, 1'b1, 1'b1, bus_result(1'b1, 8'h80));
        add_step("nmi_read_no_tandy", OP_IO_READ, io_address(`PORT_NMI_MASK_BASE),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b0, 8'h00));
        add_step("nmi_write_no_tandy", OP_IO_WRITE, io_address(`PORT_NMI_MASK_BASE),
                 8'h11, FRAME_A000, 1'b0, 1'b1, 16'h0000);
        add_step("nmi_kept", OP_IO_READ, io_address(`PORT_NMI_MASK_BASE),
                 8'h00, FRAME_A000, 1'b1, 1'b1, bus_result(1'b1, 8'h80));
        add_step("unmapped_read", OP_IO_READ, io_address(16'h0300),
                 8'h00, FRAME_A000, 1'b1, 1'b1, bus_result(1'b0, 8'h00));
        // EMS write rule
        add_step("ems_map", OP_IO_WRITE, io_address(`PORT_EMS_BASE + 16'h0001),
                 8'h12, FRAME_A000, 1'b0, 1'b1, 16'h0000);
        add_step("ems_read", OP_IO_READ, io_address(`PORT_EMS_BASE + 16'h0001),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b1, 8'h12));
        add_step("ems_keep", OP_IO_WRITE, io_address(`PORT_EMS_BASE + 16'h0001),
                 8'h90, FRAME_A000, 1'b0, 1'b1, 16'h0000);
        add_step("ems_kept", OP_IO_READ, io_address(`PORT_EMS_BASE + 16'h0001),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b1, 8'h12));
        add_step("ems_disable", OP_IO_WRITE, io_address(`PORT_EMS_BASE + 16'h0001),
                 8'hFF, FRAME_A000, 1'b0, 1'b1, 16'h0000);
        add_step("ems_disabled", OP_IO_READ, io_address(`PORT_EMS_BASE + 16'h0001),
                 8'h00, FRAME_A000, 1'b0, 1'b1, bus_result(1'b1, 8'hFF));
        // Bank hits, entry 2 mapped
        add_step("ems_map2", OP_IO_WRITE, io_address(`PORT_EMS_BASE + 16'h0002),
                 8'h05, FRAME_C000, 1'b0, 1'b1, 16'h0000);
        add_step("ems_read2", OP_IO_READ, io_address(`PORT_EMS_BASE + 16'h0002),
                 8'h00, FRAME_C000, 1'b0, 1'b1, bus_result(1'b1, 8'h05));
        add_step("probe_c8000", OP_MEM_PROBE, 20'hC8000,
                 8'h00, FRAME_C000, 1'b0, 1'b1, hit_result(4'b0100));
        add_step("probe_c4000", OP_MEM_PROBE, 20'hC4000,
                 8'h00, FRAME_C000, 1'b0, 1'b1, hit_result(4'b0000));
        add_step("probe_a8000", OP_MEM_PROBE, 20'hA8000,
                 8'h00, FRAME_C000, 1'b0, 1'b1, hit_result(4'b0000));
        add_step("probe_d8000", OP_MEM_PROBE, 20'hD8000,
                 8'h00, FRAME_D000, 1'b0, 1'b1, hit_result(4'b0100));
        // EMS ports switched off, a decoded disable would clear the bank hit
        add_step("ems_off_read", OP_IO_READ, io_address(`PORT_EMS_BASE + 16'h0002),
                 8'h00, FRAME_C000, 1'b0, 1'b0, bus_result(1'b0, 8'h00));
        add_step("ems_off_write", OP_IO_WRITE, io_address(`PORT_EMS_BASE + 16'h0002),
                 8'hFF, FRAME_C000, 1'b0, 1'b0, 16'h0000);
        add_step("ems_off_kept", OP_IO_READ, io_address(`PORT_EMS_BASE + 16'h0002),
                 8'h00, FRAME_C000, 1'b0, 1'b1, bus_result(1'b1, 8'h05));
        add_step("probe_after_off", OP_MEM_PROBE, 20'hC8000,
                 8'h00, FRAME_C000, 1'b0, 1'b1, hit_result(4'b0100));
    endtask

    // One strobe cycle, then two idle cycles
    task automatic run_step(input int idx);
        step_t   step;
        io_bus_t drive;
        string   name;
        step  = steps[idx];
        name  = step_names[idx];
        drive = idle_bus();
        drive.address    = step.address;
        drive.write_data = step.data;
        case (step.op)
            OP_IO_WRITE:  drive.io_write_n    = 1'b0;
            OP_IO_READ:   drive.io_read_n     = 1'b0;
            OP_MEM_PROBE: drive.memory_read_n = 1'b0;
            default:      ;
        endcase

        @(posedge clock);
        bus         <= drive;
        ems_enabled <= step.ems_enabled;
        tandy_video <= step.tandy_video;
        ems_frame   <= step.frame;

        @(negedge clock);
        if (step.op == OP_MEM_PROBE) begin
            check_value(name, step.expected, hit_result(ems_bank_hit));
        end
        if (step.op == OP_PAGE_CHECK) begin
            check_value(name, step.expected, page_result(tandy_page));
        end

        @(posedge clock);
        bus <= idle_bus();

        // Read data registered at the sampling edge
        @(negedge clock);
        if (step.op == OP_IO_READ) begin
            check_value(name, step.expected, bus_result(from_chipset, data_bus));
        end

        @(posedge clock);
    endtask

    initial begin
        errors      = 0;
        cycle_count = 0;
        cycle_limit = 0;
        clock       = 1'b0;
        reset       = 1'b1;
        bus         = idle_bus();
        ems_enabled = 1'b1;
        tandy_video = 1'b0;
        ems_frame   = FRAME_A000;

        build_table();
        cycle_limit = steps.size() * 4 + 20;

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
        end

        @(posedge clock);
        $display("Steps run: %0d, errors: %0d", steps.size(), errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
design/peripheral_pkg.sv
design/io_port_decoder.sv
design/ems_mapper.sv
design/io_latch_bank.sv
design/readback_mux.sv
design/peripheral_glue_top.sv
test/tb_peripheral_glue.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the peripheral glue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -sv -f list.f \
    --top-module tb_peripheral_glue -o sim_peripheral_glue

./obj_dir/sim_peripheral_glue | tee sim.log

if grep -q "^\*\* PASS \*\*$" sim.log; then
    exit 0
else
    exit 1
fi
